/* design/alu.sv */
module alu (
    input  logic [63:0]                 pc,
    input  logic [63:0]                 rs1_data,
    input  logic [63:0]                 rs2_data,
    input  logic [63:0]                 imm_i,
    input  logic [63:0]                 imm_s,
    input  logic [63:0]                 imm_u,
    input  logic [rv_pkg::alu_op_w-1:0] alu_op,
    input  logic [rv_pkg::src1_w-1:0]   sel_alusrc1,
    input  logic [rv_pkg::src2_w-1:0]   sel_alusrc2,
    input  logic [rv_pkg::alures_w-1:0] sel_alures,
    input  logic [rv_pkg::npc_w-1:0]    sel_nextpc,
    output logic [63:0]                 alu_result,
    output logic                        branch_cond
);
    import rv_pkg::*;

    logic [63:0] a, b, sum, diff, res;
    logic [5:0]  shamt;
    logic        slt, sltu, eq, lt;

    assign a = {64{sel_alusrc1[0]}} & rs1_data
             | {64{sel_alusrc1[1]}} & pc;
    assign b = {64{sel_alusrc2[0]}} & rs2_data
             | {64{sel_alusrc2[1]}} & imm_i
             | {64{sel_alusrc2[2]}} & imm_u
             | {64{sel_alusrc2[3]}} & 64'd4
             | {64{sel_alusrc2[4]}} & imm_s;

    assign sum   = a + b;
    assign diff  = a - b;
    assign slt   = $signed(a) < $signed(b);
    assign sltu  = a < b;
    assign shamt = b[5:0];

    assign res = {64{alu_op[0]}} & sum
               | {64{alu_op[1]}} & diff
               | {64{alu_op[2]}} & {63'd0, slt}
               | {64{alu_op[3]}} & {63'd0, sltu}
               | {64{alu_op[4]}} & (a & b)
               | {64{alu_op[5]}} & (a | b)
               | {64{alu_op[6]}} & (a ^ b)
               | {64{alu_op[7]}} & (a << shamt)
               | {64{alu_op[8]}} & (a >> shamt)
               | {64{alu_op[9]}} & 64'($signed(a) >>> shamt)
               | {64{alu_op[10]}} & b;  // lui passes imm_u

    assign alu_result = {64{sel_alures[0]}} & res
                      | {64{sel_alures[1]}} & {{32{res[31]}}, res[31:0]};

    // branch operands are rs1/rs2, so the compare paths above apply
    assign eq = diff == 64'd0;
    assign lt = alu_op[2] ? slt : sltu;
    assign branch_cond = sel_nextpc[3] & eq
                       | sel_nextpc[4] & ~eq
                       | sel_nextpc[5] & lt
                       | sel_nextpc[6] & ~lt;

endmodule

/* design/control_unit.sv */
module control_unit (
    input  logic [6:0]                  opcode,
    input  logic [2:0]                  funct3,
    input  logic [6:0]                  funct7,
    output logic [rv_pkg::alu_op_w-1:0] alu_op,
    output logic                        rf_we,
    output logic [rv_pkg::src1_w-1:0]   sel_alusrc1,
    output logic [rv_pkg::src2_w-1:0]   sel_alusrc2,
    output logic [rv_pkg::npc_w-1:0]    sel_nextpc,
    output logic [rv_pkg::rfres_w-1:0]  sel_rfres,
    output logic                        mem_ena,
    output logic                        mem_wen,
    output logic [rv_pkg::mask_w-1:0]   mem_mask,
    output logic                        inv,
    output logic [rv_pkg::alures_w-1:0] sel_alures
);
    import rv_pkg::*;

    logic is_imm, is_reg, is_br, is_ld, is_st, f7_zero, f7_alt;
    logic inst_addi, inst_sltiu, inst_andi, inst_slli, inst_srli, inst_srai, inst_addiw;
    logic inst_lui, inst_auipc, inst_jal, inst_jalr;
    logic inst_add, inst_sub, inst_and, inst_or, inst_xor, inst_slt, inst_sltu;
    logic inst_sll, inst_srl, inst_sra, inst_addw;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic inst_ld, inst_lw, inst_lwu, inst_lh, inst_lhu, inst_lb, inst_lbu;
    logic inst_sd, inst_sw, inst_sh, inst_sb;
    logic r_type, b_type, i_alu, load, store;

    assign is_imm  = opcode == op_imm;
    assign is_reg  = opcode == op_reg;
    assign is_br   = opcode == op_branch;
    assign is_ld   = opcode == op_load;
    assign is_st   = opcode == op_store;
    assign f7_zero = funct7 == 7'b0000000;
    assign f7_alt  = funct7 == 7'b0100000;

    assign inst_addi  = is_imm && funct3 == 3'b000;
    assign inst_sltiu = is_imm && funct3 == 3'b011;
    assign inst_andi  = is_imm && funct3 == 3'b111;
    assign inst_slli  = is_imm && funct3 == 3'b001 && funct7[6:1] == 6'b000000;
    assign inst_srli  = is_imm && funct3 == 3'b101 && funct7[6:1] == 6'b000000;
    assign inst_srai  = is_imm && funct3 == 3'b101 && funct7[6:1] == 6'b010000;
    assign inst_addiw = opcode == op_imm32 && funct3 == 3'b000;
    assign inst_lui   = opcode == op_lui;
    assign inst_auipc = opcode == op_auipc;
    assign inst_jal   = opcode == op_jal;
    assign inst_jalr  = opcode == op_jalr && funct3 == 3'b000;

    assign inst_add  = is_reg && funct3 == 3'b000 && f7_zero;
    assign inst_sub  = is_reg && funct3 == 3'b000 && f7_alt;
    assign inst_sll  = is_reg && funct3 == 3'b001 && f7_zero;
    assign inst_slt  = is_reg && funct3 == 3'b010 && f7_zero;
    assign inst_sltu = is_reg && funct3 == 3'b011 && f7_zero;
    assign inst_xor  = is_reg && funct3 == 3'b100 && f7_zero;
    assign inst_srl  = is_reg && funct3 == 3'b101 && f7_zero;
    assign inst_sra  = is_reg && funct3 == 3'b101 && f7_alt;
    assign inst_or   = is_reg && funct3 == 3'b110 && f7_zero;
    assign inst_and  = is_reg && funct3 == 3'b111 && f7_zero;
    assign inst_addw = opcode == op_reg32 && funct3 == 3'b000 && f7_zero;

    assign inst_beq  = is_br && funct3 == 3'b000;
    assign inst_bne  = is_br && funct3 == 3'b001;
    assign inst_blt  = is_br && funct3 == 3'b100;
    assign inst_bge  = is_br && funct3 == 3'b101;
    assign inst_bltu = is_br && funct3 == 3'b110;
    assign inst_bgeu = is_br && funct3 == 3'b111;

    assign inst_lb  = is_ld && funct3 == 3'b000;
    assign inst_lh  = is_ld && funct3 == 3'b001;
    assign inst_lw  = is_ld && funct3 == 3'b010;
    assign inst_ld  = is_ld && funct3 == 3'b011;
    assign inst_lbu = is_ld && funct3 == 3'b100;
    assign inst_lhu = is_ld && funct3 == 3'b101;
    assign inst_lwu = is_ld && funct3 == 3'b110;
    assign inst_sb  = is_st && funct3 == 3'b000;
    assign inst_sh  = is_st && funct3 == 3'b001;
    assign inst_sw  = is_st && funct3 == 3'b010;
    assign inst_sd  = is_st && funct3 == 3'b011;

    assign r_type = inst_add | inst_sub | inst_and | inst_or | inst_xor | inst_slt | inst_sltu
                  | inst_sll | inst_srl | inst_sra | inst_addw;
    assign b_type = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    assign i_alu  = inst_addi | inst_sltiu | inst_andi | inst_slli | inst_srli | inst_srai
                  | inst_addiw;
    assign load   = inst_ld | inst_lw | inst_lwu | inst_lh | inst_lhu | inst_lb | inst_lbu;
    assign store  = inst_sd | inst_sw | inst_sh | inst_sb;

    assign inv = ~(r_type | b_type | i_alu | load | store
                 | inst_lui | inst_auipc | inst_jal | inst_jalr);

    assign alu_op = {inst_lui,
                     inst_sra | inst_srai,
                     inst_srl | inst_srli,
                     inst_sll | inst_slli,
                     inst_xor,
                     inst_or,
                     inst_and | inst_andi,
                     inst_sltu | inst_sltiu | inst_bltu | inst_bgeu,
                     inst_slt | inst_blt | inst_bge,
                     inst_sub | inst_beq | inst_bne,
                     inst_add | inst_addi | inst_addw | inst_addiw | inst_auipc
                         | inst_jal | inst_jalr | load | store};

    assign rf_we       = r_type | i_alu | load | inst_lui | inst_auipc | inst_jal | inst_jalr;
    assign sel_alusrc1 = {inst_auipc | inst_jal, r_type | b_type | i_alu | load | store | inst_jalr};
    assign sel_alusrc2 = {store, inst_jal, inst_lui | inst_auipc, i_alu | load | inst_jalr,
                          r_type | b_type};
    assign sel_nextpc  = {inst_bge | inst_bgeu, inst_blt | inst_bltu, inst_bne, inst_beq,
                          inst_jalr, inst_jal,
                          r_type | i_alu | load | store | inst_lui | inst_auipc};
    assign sel_rfres   = {inst_lwu | inst_lhu | inst_lbu, inst_ld | inst_lw | inst_lh | inst_lb,
                          ~load};

    assign mem_ena  = load | store;
    assign mem_wen  = store;
    assign mem_mask = {inst_lb | inst_lbu | inst_sb, inst_lh | inst_lhu | inst_sh,
                       inst_lw | inst_lwu | inst_sw, inst_ld | inst_sd};

    assign sel_alures = {inst_addw | inst_addiw, ~(inst_addw | inst_addiw)};

endmodule

/* design/core_top.sv */
module core_top (
    input  logic        clk,
    input  logic        reset,
    output logic        imem_req,
    output logic [63:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic        dmem_req,
    output logic        dmem_we,
    output logic [63:0] dmem_addr,
    output logic [63:0] dmem_wdata,
    output logic [7:0]  dmem_strb,
    input  logic [63:0] dmem_rdata,
    output logic        commit_valid,
    output logic [63:0] commit_pc,
    output logic [4:0]  commit_rd,
    output logic        commit_we,
    output logic [63:0] commit_wdata,
    output logic        halt
);
    import rv_pkg::*;

    logic [ph_w-1:0]     phase;
    logic [63:0]         pc;
    logic [4:0]          rs1, rs2, rd;
    logic [63:0]         imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [alu_op_w-1:0] alu_op;
    logic [src1_w-1:0]   sel_alusrc1;
    logic [src2_w-1:0]   sel_alusrc2;
    logic [npc_w-1:0]    sel_nextpc;
    logic [rfres_w-1:0]  sel_rfres;
    logic [mask_w-1:0]   mem_mask;
    logic [alures_w-1:0] sel_alures;
    logic                rf_we, mem_ena, mem_wen, inv, is_load;
    logic [63:0]         rs1_data, rs2_data, alu_result, ex_result, wb_data;
    logic                branch_cond, wb_en;

    assign is_load = mem_ena & ~mem_wen;
    // alu carries the jalr target, so the link comes from here
    assign ex_result = sel_nextpc[2] ? pc + 64'd4 : alu_result;

    fetch_unit u_fetch (
        .clk, .reset, .branch_cond, .inv, .is_load, .sel_nextpc, .alu_result,
        .imm_b, .imm_j, .phase, .pc, .imem_req, .imem_addr, .halt
    );

    decode_unit u_decode (
        .clk, .reset, .phase, .imem_data, .rs1, .rs2, .rd,
        .imm_i, .imm_s, .imm_b, .imm_u, .imm_j, .alu_op, .rf_we,
        .sel_alusrc1, .sel_alusrc2, .sel_nextpc, .sel_rfres,
        .mem_ena, .mem_wen, .mem_mask, .inv, .sel_alures
    );

    regfile u_regfile (
        .clk, .reset, .we(wb_en), .rs1, .rs2, .rd, .wdata(wb_data), .rs1_data, .rs2_data
    );

    alu u_alu (
        .pc, .rs1_data, .rs2_data, .imm_i, .imm_s, .imm_u, .alu_op,
        .sel_alusrc1, .sel_alusrc2, .sel_alures, .sel_nextpc, .alu_result, .branch_cond
    );

    lsu u_lsu (
        .clk, .phase, .mem_ena, .mem_wen, .mem_mask, .sel_rfres,
        .alu_result(ex_result), .rs2_data, .dmem_rdata, .rf_we_dec(rf_we),
        .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_strb, .wb_data, .wb_en
    );

    // loads retire in the memory phase, everything else in execute
    assign commit_valid = (phase == ph_exec && !inv && !is_load) || phase == ph_mem;
    assign commit_pc    = pc;
    assign commit_rd    = rd;
    assign commit_we    = wb_en;
    assign commit_wdata = wb_data;

endmodule

/* design/decode_unit.sv */
module decode_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [rv_pkg::ph_w-1:0]     phase,
    input  logic [31:0]                 imem_data,
    output logic [4:0]                  rs1,
    output logic [4:0]                  rs2,
    output logic [4:0]                  rd,
    output logic [63:0]                 imm_i,
    output logic [63:0]                 imm_s,
    output logic [63:0]                 imm_b,
    output logic [63:0]                 imm_u,
    output logic [63:0]                 imm_j,
    output logic [rv_pkg::alu_op_w-1:0] alu_op,
    output logic                        rf_we,
    output logic [rv_pkg::src1_w-1:0]   sel_alusrc1,
    output logic [rv_pkg::src2_w-1:0]   sel_alusrc2,
    output logic [rv_pkg::npc_w-1:0]    sel_nextpc,
    output logic [rv_pkg::rfres_w-1:0]  sel_rfres,
    output logic                        mem_ena,
    output logic                        mem_wen,
    output logic [rv_pkg::mask_w-1:0]   mem_mask,
    output logic                        inv,
    output logic [rv_pkg::alures_w-1:0] sel_alures
);
    import rv_pkg::*;

    inst_word_t inst_q, inst;

    always_ff @(posedge clk) begin
        if (reset) inst_q <= '0;
        else if (phase == ph_exec) inst_q <= imem_data;
    end

    // live word in execute, held copy for the load memory phase
    assign inst = (phase == ph_exec) ? inst_word_t'(imem_data) : inst_q;

    assign rs1 = inst.r_fmt.rs1;
    assign rs2 = inst.r_fmt.rs2;
    assign rd  = inst.r_fmt.rd;

    assign imm_i = {{52{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{52{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign imm_b = {{52{inst.b_fmt.imm12}}, inst.b_fmt.imm11, inst.b_fmt.imm10_5,
                    inst.b_fmt.imm4_1, 1'b0};
    assign imm_u = {{32{inst.u_fmt.imm[19]}}, inst.u_fmt.imm, 12'h000};
    assign imm_j = {{44{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
                    inst.j_fmt.imm10_1, 1'b0};

    control_unit u_ctrl (
        .opcode(inst.r_fmt.opcode), .funct3(inst.r_fmt.funct3), .funct7(inst.r_fmt.funct7),
        .alu_op, .rf_we, .sel_alusrc1, .sel_alusrc2, .sel_nextpc, .sel_rfres,
        .mem_ena, .mem_wen, .mem_mask, .inv, .sel_alures
    );

endmodule

/* design/fetch_unit.sv */
module fetch_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     branch_cond,
    input  logic                     inv,
    input  logic                     is_load,
    input  logic [rv_pkg::npc_w-1:0] sel_nextpc,
    input  logic [63:0]              alu_result,
    input  logic [63:0]              imm_b,
    input  logic [63:0]              imm_j,
    output logic [rv_pkg::ph_w-1:0]  phase,
    output logic [63:0]              pc,
    output logic                     imem_req,
    output logic [63:0]              imem_addr,
    output logic                     halt
);
    import rv_pkg::*;

    logic        halt_q, is_br, take;
    logic [63:0] next_pc;

    assign is_br = |sel_nextpc[6:3];
    assign take  = is_br & branch_cond;

    assign next_pc = {64{sel_nextpc[0] | (is_br & ~branch_cond)}} & (pc + 64'd4)
                   | {64{sel_nextpc[1]}} & (pc + imm_j)
                   | {64{sel_nextpc[2]}} & {alu_result[63:1], 1'b0}
                   | {64{take}} & (pc + imm_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= reset_pc;
            phase  <= ph_fetch;
            halt_q <= 1'b0;
        end else begin
            case (phase)
                ph_fetch: if (!halt_q) phase <= ph_exec;
                ph_exec: begin
                    if (inv) begin
                        halt_q <= 1'b1;  // sticky until reset
                        phase  <= ph_fetch;
                    end else if (is_load) begin
                        phase <= ph_mem;
                    end else begin
                        pc    <= next_pc;
                        phase <= ph_fetch;
                    end
                end
                default: begin
                    pc    <= next_pc;
                    phase <= ph_fetch;
                end
            endcase
        end
    end

    assign imem_req  = phase == ph_fetch && !halt_q && !reset;
    assign imem_addr = pc;
    assign halt      = halt_q | (phase == ph_exec && inv);

endmodule

/* design/lsu.sv */
module lsu (
    input  logic                       clk,
    input  logic [rv_pkg::ph_w-1:0]    phase,
    input  logic                       mem_ena,
    input  logic                       mem_wen,
    input  logic [rv_pkg::mask_w-1:0]  mem_mask,
    input  logic [rv_pkg::rfres_w-1:0] sel_rfres,
    input  logic [63:0]                alu_result,
    input  logic [63:0]                rs2_data,
    input  logic [63:0]                dmem_rdata,
    input  logic                       rf_we_dec,
    output logic                       dmem_req,
    output logic                       dmem_we,
    output logic [63:0]                dmem_addr,
    output logic [63:0]                dmem_wdata,
    output logic [7:0]                 dmem_strb,
    output logic [63:0]                wb_data,
    output logic                       wb_en
);
    import rv_pkg::*;

    logic [2:0]        off, off_q;
    logic [mask_w-1:0] mask_q;
    logic [63:0]       sh, ld_val;
    logic              sgn;

    assign off       = alu_result[2:0];
    assign dmem_req  = mem_ena && phase == ph_exec;
    assign dmem_we   = mem_wen && phase == ph_exec;
    assign dmem_addr = {alu_result[63:3], 3'b000};

    // replicate store data across all lanes, strobes pick the lane
    assign dmem_wdata = {64{mem_mask[0]}} & rs2_data
                      | {64{mem_mask[1]}} & {2{rs2_data[31:0]}}
                      | {64{mem_mask[2]}} & {4{rs2_data[15:0]}}
                      | {64{mem_mask[3]}} & {8{rs2_data[7:0]}};
    assign dmem_strb  = {8{mem_mask[0]}} & 8'hff
                      | {8{mem_mask[1]}} & (8'h0f << off)
                      | {8{mem_mask[2]}} & (8'h03 << off)
                      | {8{mem_mask[3]}} & (8'h01 << off);

    always_ff @(posedge clk) begin
        if (phase == ph_exec) begin
            off_q  <= off;
            mask_q <= mem_mask;
        end
    end

    assign sh  = dmem_rdata >> {off_q, 3'b000};
    assign sgn = sel_rfres[1];  // lb lh lw ld
    assign ld_val = {64{mask_q[0]}} & sh
                  | {64{mask_q[1]}} & {{32{sgn & sh[31]}}, sh[31:0]}
                  | {64{mask_q[2]}} & {{48{sgn & sh[15]}}, sh[15:0]}
                  | {64{mask_q[3]}} & {{56{sgn & sh[7]}}, sh[7:0]};

    assign wb_data = {64{sel_rfres[0]}} & alu_result
                   | {64{sel_rfres[1] | sel_rfres[2]}} & ld_val;
    // alu results write in execute, loads in the memory phase
    assign wb_en = rf_we_dec && ((phase == ph_exec && sel_rfres[0]) || phase == ph_mem);

endmodule

/* design/regfile.sv */
module regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [63:0] wdata,
    output logic [63:0] rs1_data,
    output logic [63:0] rs2_data
);

    logic [63:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? 64'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

    // base opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_imm32  = 7'b0011011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_reg32  = 7'b0111011;

    // one-hot select widths
    localparam int alu_op_w = 11;  // add sub slt sltu and or xor sll srl sra lui
    localparam int src1_w   = 2;   // rs1, pc
    localparam int src2_w   = 5;   // rs2, imm_i, imm_u, 4, imm_s
    localparam int npc_w    = 7;   // seq jal jalr beq bne lt ge
    localparam int rfres_w  = 3;   // alu, signed load, unsigned load
    localparam int mask_w   = 4;   // d w h b
    localparam int alures_w = 2;   // full, 32-bit sign extended

    // sequencer phases
    localparam int         ph_w     = 2;
    localparam logic [1:0] ph_fetch = 2'd0;
    localparam logic [1:0] ph_exec  = 2'd1;
    localparam logic [1:0] ph_mem   = 2'd2;

    localparam logic [63:0] reset_pc = 64'h0000_0000_8000_0000;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_word_t;

endpackage

/* list.f */
+incdir+tests
design/rv_pkg.sv
design/regfile.sv
design/alu.sv
design/control_unit.sv
design/decode_unit.sv
design/fetch_unit.sv
design/lsu.sv
design/core_top.sv
tests/tb_core.sv

/* tests/tb_ref_model.svh */
// architectural state, stepped once per commit
logic [63:0] ref_pc;
logic [63:0] ref_x [0:31];
logic [7:0]  ref_mem [0:2047];
logic [31:0] lfsr_state = 32'd96264;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v = {v[62:0], fb};  // one step per bit
    end
    return v;
endfunction

function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
endfunction

function automatic logic [31:0] b_word(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
endfunction

function automatic logic [31:0] u_word(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] j_word(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

task automatic ref_exec(input logic [31:0] w, output logic we, output logic [63:0] res);
    logic [63:0] a, b, o2, ii, ui, ea, npc;
    logic        take;
    int          nb;
    a   = ref_x[w[19:15]];
    b   = ref_x[w[24:20]];
    ii  = {{52{w[31]}}, w[31:20]};
    ui  = {{32{w[31]}}, w[31:12], 12'h000};
    ea  = a + ((w[6:0] == op_store) ? {{52{w[31]}}, w[31:25], w[11:7]} : ii);
    o2  = w[5] ? b : ii;  // reg forms take rs2
    nb  = 1 << w[13:12];
    npc = ref_pc + 64'd4;
    we  = 1'b1;
    res = '0;
    case (w[6:0])
        op_imm, op_reg, op_imm32, op_reg32: begin
            case (w[14:12])
                3'b000: res = (w[5] && w[30]) ? a - o2 : a + o2;
                3'b001: res = a << o2[5:0];
                3'b010: res = {63'd0, $signed(a) < $signed(o2)};
                3'b011: res = {63'd0, a < o2};
                3'b100: res = a ^ o2;
                3'b101: if (w[30]) res = $signed(a) >>> o2[5:0]; else res = a >> o2[5:0];
                3'b110: res = a | o2;
                default: res = a & o2;
            endcase
            if (w[3]) res = {{32{res[31]}}, res[31:0]};  // W forms
        end
        op_lui:   res = ui;
        op_auipc: res = ref_pc + ui;
        op_jal: begin
            res = ref_pc + 64'd4;
            npc = ref_pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        op_jalr: begin
            res = ref_pc + 64'd4;
            npc = (a + ii) & ~64'd1;
        end
        op_branch: begin
            we = 1'b0;
            case (w[14:12])
                3'b000: take = a == b;
                3'b001: take = a != b;
                3'b100: take = $signed(a) < $signed(b);
                3'b101: take = $signed(a) >= $signed(b);
                3'b110: take = a < b;
                default: take = a >= b;
            endcase
            if (take) npc = ref_pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        op_load: begin
            for (int i = 0; i < nb; i++) res[8 * i +: 8] = ref_mem[ea[10:0] + i];
            if (!w[14] && nb < 8 && res[8 * nb - 1]) res = res | (~64'd0 << (8 * nb));
        end
        op_store: begin
            we = 1'b0;
            for (int i = 0; i < nb; i++) ref_mem[ea[10:0] + i] = b[8 * i +: 8];
        end
        default: we = 1'b0;
    endcase
    if (we && w[11:7] != 5'd0) ref_x[w[11:7]] = res;
    ref_pc = npc;
endtask

/* tests/tb_core.sv */
module tb_core;
    import rv_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] imem_data;
    logic [63:0] dmem_rdata;
    logic        imem_req, dmem_req, dmem_we, commit_valid, commit_we, halt;
    logic [63:0] imem_addr, dmem_addr, dmem_wdata, commit_pc, commit_wdata;
    logic [7:0]  dmem_strb;
    logic [4:0]  commit_rd;

    logic [31:0] imem [0:255];
    logic [63:0] dmem [0:255];
    logic [63:0] sect_end [0:4];
    string       sect_name [0:4] = '{"alu ops", "x0 writes", "jumps", "branches", "load store"};
    int          wp, limit, cur = 0, errors = 0, errs_mark = 0, n_pass = 0, n_fail = 0;
    int          cycles = 0;
    logic [31:0] cw;
    logic [63:0] exp_pc, exp_wd;
    logic        exp_we;

    `include "tb_ref_model.svh"

    // fixed bits of add sub and or xor slt sltu sll srl sra addw, then the immediate forms
    logic [31:0] alu_tmpl [0:17] = '{
        32'h00000033, 32'h40000033, 32'h00007033, 32'h00006033, 32'h00004033, 32'h00002033,
        32'h00003033, 32'h00001033, 32'h00005033, 32'h40005033, 32'h0000003b, 32'h00000013,
        32'h00003013, 32'h00007013, 32'h00001013, 32'h00005013, 32'h40005013, 32'h0000001b};

    core_top dut0 (.*);

    always #2 clk = ~clk;

    // memories answer one cycle after the request
    always @(posedge clk) begin
        if (imem_req) imem_data <= imem[imem_addr[9:2]];
        if (dmem_req && dmem_we) begin
            for (int i = 0; i < 8; i++)
                if (dmem_strb[i]) dmem[dmem_addr[10:3]][8 * i +: 8] <= dmem_wdata[8 * i +: 8];
        end else if (dmem_req) begin
            dmem_rdata <= dmem[dmem_addr[10:3]];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == limit) begin
            $display("timeout after %0d cycles, program did not run to the halt", limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("Mismatch %s: got %0h expected %0h", name, got, exp);
        errors++;
    endtask

    task automatic finish_test(input string name);
        if (errors == errs_mark) begin
            n_pass++;
            $display("test %s: passed", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, errors - errs_mark);
        end
        errs_mark = errors;
    endtask

    function automatic logic [31:0] alu_word(int kind, logic [4:0] rd, logic [4:0] rs1,
                                             logic [31:0] hi);
        logic [31:0] free;
        free = kind < 11 ? 32'h0070_0000 : (kind >= 14 && kind <= 16) ? 32'h03f0_0000
                                                                      : 32'hfff0_0000;
        return alu_tmpl[kind] | (hi & free) | {rs1, 15'd0} | {rd, 7'd0};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[wp] = w;
        wp++;
    endtask

    task automatic build_program;
        logic [4:0] r, s, t;
        logic [2:0] f3;
        logic [9:0] off;
        wp = 0;
        for (int n = 1; n < 8; n++) begin  // random 64-bit operands
            emit(u_word(rand_bits(20), n, op_lui));
            emit(i_word(rand_bits(6), n, 3'b001, n, op_imm));
            emit(i_word(rand_bits(12), n, 3'b000, n, op_imm));
        end
        for (int k = 0; k < 60; k++)  // each kind at least three times
            emit(alu_word(k % 18, rand_bits(3), rand_bits(3), rand_bits(32)));
        sect_end[0] = reset_pc + 4 * wp;
        emit(i_word(12'h123, 1, 3'b000, 0, op_imm));
        emit(alu_word(0, 8, 0, 0));
        emit(alu_word(1, 9, 0, 32'h0010_0000));  // x9 = x0 - x1
        sect_end[1] = reset_pc + 4 * wp;
        for (int k = 0; k < 4; k++) begin
            r = rand_bits(3);
            emit(u_word(rand_bits(20), r, op_lui));
            emit(u_word(rand_bits(20), r + 5'd8, op_auipc));
            emit(j_word(21'd8, r));
            emit(i_word(12'd1, 8, 3'b000, 8, op_imm));  // skipped
            emit(u_word(20'd0, 10, op_auipc));
            emit(i_word(12'd13, 10, 3'b000, r, op_jalr));  // odd target loses bit 0
            emit(i_word(12'd1, 8, 3'b000, 8, op_imm));
        end
        sect_end[2] = reset_pc + 4 * wp;
        for (int k = 0; k < 24; k++) begin
            f3 = (k % 6 < 2) ? k % 6 : k % 6 + 2;
            s  = rand_bits(3);
            t  = (k % 12 < 6) ? s : 5'(rand_bits(3));
            emit(b_word(13'd8, t, s, f3));
            emit(i_word(12'd1, 8, 3'b000, 8, op_imm));
        end
        sect_end[3] = reset_pc + 4 * wp;
        emit(i_word(12'h400, 0, 3'b000, 10, op_imm));  // data base in x10
        for (int k = 0; k < 16; k++) begin
            f3  = k % 4;  // sb sh sw sd in turn
            off = rand_bits(10);
            off = off & ~((10'd1 << f3[1:0]) - 10'd1);
            emit(s_word(off, rand_bits(3), 10, f3));
            f3  = k % 7;  // lb up to lwu
            off = {off[9:3], 3'(rand_bits(3))};
            off = off & ~((10'd1 << f3[1:0]) - 10'd1);
            emit(i_word(off, 10, f3, rand_bits(3), op_load));
        end
        sect_end[4] = reset_pc + 4 * wp;
        emit(32'h0000_0000);
    endtask

    always @(posedge clk) begin
        if (!reset && commit_valid) begin
            assert (cur < 5) else begin
                $display("unexpected commit at pc %0h after the last instruction", commit_pc);
                errors++;
            end
            cw     = imem[ref_pc[9:2]];
            exp_pc = ref_pc;
            ref_exec(cw, exp_we, exp_wd);
            assert (commit_pc == exp_pc) else mismatch("commit_pc", commit_pc, exp_pc);
            assert (commit_we == exp_we) else mismatch("commit_we", commit_we, exp_we);
            if (exp_we) begin
                assert (commit_rd == cw[11:7]) else mismatch("commit_rd", commit_rd, cw[11:7]);
                assert (commit_wdata == exp_wd)
                    else mismatch("commit_wdata", commit_wdata, exp_wd);
            end
            if (cur < 5 && ref_pc == sect_end[cur]) begin
                finish_test(sect_name[cur]);
                cur++;
            end
        end
    end

    initial begin
        reset      = 1'b1;
        imem_data  = '0;
        dmem_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = {i * 32'h9e37_79b9, ~i};
            for (int k = 0; k < 8; k++) ref_mem[8 * i + k] = dmem[i][8 * k +: 8];
        end
        for (int i = 0; i < 32; i++) ref_x[i] = '0;
        ref_pc = reset_pc;
        build_program();
        limit = wp * 3 + 50;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        wait (cur == 5);
        for (int a = 0; a < 2048; a++)
            assert (dmem[a / 8][8 * (a % 8) +: 8] == ref_mem[a])
                else mismatch($sformatf("dmem byte %0h", a), dmem[a / 8][8 * (a % 8) +: 8],
                              ref_mem[a]);
        finish_test("memory");
        while (!halt) @(posedge clk);
        repeat (20) begin
            @(posedge clk);
            assert (!commit_valid && halt) else begin
                $display("core committed or left halt after the all-zero word");
                errors++;
            end
        end
        finish_test("halt");
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
